// ==== hdl/rv_isa_pkg.sv ====
// --------------------------------------------------------------------
// RV32I ISA definitions
// Data word, register index and the instruction field types, plus
// the major opcodes and funct encodings used by the execution slice
// --------------------------------------------------------------------

package rv_isa_pkg;

    // Architectural data width
    localparam int XLEN = 32;

    // One data word, also one instruction word
    typedef logic [XLEN-1:0] word_t;

    // Register index as encoded in the instruction, x0..x31
    typedef logic [4:0] reg_idx_t;

    // Instruction field types
    typedef logic [6:0] opcode_t;
    typedef logic [2:0] funct3_t;
    typedef logic [6:0] funct7_t;

    // Major opcodes, low two bits always 11 for 32-bit encodings
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;

    // funct3 for OP and OP-IMM
    // ADD/SUB and SRL/SRA share a code, told apart by instruction bit 30
    localparam funct3_t F3_ADD_SUB = 3'b000;
    localparam funct3_t F3_SLL     = 3'b001;
    localparam funct3_t F3_SLT     = 3'b010;
    localparam funct3_t F3_SLTU    = 3'b011;
    localparam funct3_t F3_XOR     = 3'b100;
    localparam funct3_t F3_SRL_SRA = 3'b101;
    localparam funct3_t F3_OR      = 3'b110;
    localparam funct3_t F3_AND     = 3'b111;

    // funct7 values, also the upper immediate bits of shift-immediates
    localparam funct7_t F7_BASE = 7'b0000000;
    // Alternate form, bit 30 set (SUB, SRA, SRAI)
    localparam funct7_t F7_ALT  = 7'b0100000;

endpackage

// ==== hdl/core_pkg.sv ====
// --------------------------------------------------------------------
// Execution slice microarchitecture types
// ALU operation codes, the decoded instruction and the retire record
// --------------------------------------------------------------------

package core_pkg;

    // ALU operations, PASS_B forwards operand B for LUI
    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        ALU_PASS_B = 4'd10
    } alu_op_t;

    // Output of the decoder, carried into the execute stage
    typedef struct packed {
        // Source indices, zero when the format has no such field
        rv_isa_pkg::reg_idx_t rs1;
        rv_isa_pkg::reg_idx_t rs2;
        rv_isa_pkg::reg_idx_t rd;
        // Sign-extended I or shifted U immediate
        rv_isa_pkg::word_t    imm;
        // Operand B from imm instead of rs2
        logic                 use_imm;
        // Operand A from pc (AUIPC)
        logic                 use_pc;
        // Operand A forced to zero (LUI)
        logic                 zero_a;
        alu_op_t              alu_op;
        logic                 wen;
        logic                 illegal;
    } decoded_t;

    // One retired instruction
    typedef struct packed {
        rv_isa_pkg::reg_idx_t rd;
        rv_isa_pkg::word_t    value;
        logic                 illegal;
    } retire_t;

endpackage

// ==== hdl/core_decode.sv ====
// --------------------------------------------------------------------
// RV32I/RV32E instruction decoder
// Combinational split of an instruction word into register indices,
// immediate, ALU operation, operand selects and legality
// --------------------------------------------------------------------

`timescale 1ns/1ps

module core_decode #(
    parameter int NUM_REGS = 32
) (
    input  rv_isa_pkg::word_t  instr,
    output core_pkg::decoded_t dec
);

    rv_isa_pkg::opcode_t opcode;
    rv_isa_pkg::funct3_t funct3;
    rv_isa_pkg::funct7_t funct7;
    rv_isa_pkg::word_t   imm_i;
    rv_isa_pkg::word_t   imm_u;
    logic                bad_opcode;
    logic                bad_funct7;

    // Fixed field positions
    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // I-type sign-extended, U-type in the upper 20 bits
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_u = {instr[31:12], 12'b0};

    // Index within the implemented register count (RV32E has 16)
    function automatic logic idx_ok(input rv_isa_pkg::reg_idx_t idx);
        return int'(idx) < NUM_REGS;
    endfunction

    // funct3 to ALU op, alt picks SUB over ADD and SRA over SRL
    function automatic core_pkg::alu_op_t f3_op(input rv_isa_pkg::funct3_t f3,
                                                input logic alt);
        core_pkg::alu_op_t op;
        case (f3)
            rv_isa_pkg::F3_ADD_SUB: op = alt ? core_pkg::ALU_SUB : core_pkg::ALU_ADD;
            rv_isa_pkg::F3_SLL:     op = core_pkg::ALU_SLL;
            rv_isa_pkg::F3_SLT:     op = core_pkg::ALU_SLT;
            rv_isa_pkg::F3_SLTU:    op = core_pkg::ALU_SLTU;
            rv_isa_pkg::F3_XOR:     op = core_pkg::ALU_XOR;
            rv_isa_pkg::F3_SRL_SRA: op = alt ? core_pkg::ALU_SRA : core_pkg::ALU_SRL;
            rv_isa_pkg::F3_OR:      op = core_pkg::ALU_OR;
            default:                op = core_pkg::ALU_AND;
        endcase
        return op;
    endfunction

    always_comb begin
        dec        = '0;
        dec.rd     = instr[11:7];
        dec.alu_op = core_pkg::ALU_ADD;
        bad_opcode = 1'b0;
        bad_funct7 = 1'b0;

        case (opcode)
            rv_isa_pkg::OPC_OP: begin
                dec.rs1    = instr[19:15];
                dec.rs2    = instr[24:20];
                dec.alu_op = f3_op(funct3, instr[30]);
                // Alternate funct7 only exists for SUB and SRA
                if (funct7 == rv_isa_pkg::F7_ALT) begin
                    bad_funct7 = (funct3 != rv_isa_pkg::F3_ADD_SUB) &&
                                 (funct3 != rv_isa_pkg::F3_SRL_SRA);
                end else begin
                    bad_funct7 = (funct7 != rv_isa_pkg::F7_BASE);
                end
            end
            rv_isa_pkg::OPC_OP_IMM: begin
                dec.rs1     = instr[19:15];
                dec.imm     = imm_i;
                dec.use_imm = 1'b1;
                // ADDI has no SUB form, bit 30 only matters for shifts
                dec.alu_op  = f3_op(funct3,
                                    instr[30] && (funct3 == rv_isa_pkg::F3_SRL_SRA));
                // Upper immediate bits are funct7 for the shift forms
                if (funct3 == rv_isa_pkg::F3_SLL) begin
                    bad_funct7 = (funct7 != rv_isa_pkg::F7_BASE);
                end else if (funct3 == rv_isa_pkg::F3_SRL_SRA) begin
                    bad_funct7 = (funct7 != rv_isa_pkg::F7_BASE) &&
                                 (funct7 != rv_isa_pkg::F7_ALT);
                end
            end
            rv_isa_pkg::OPC_LUI: begin
                dec.imm     = imm_u;
                dec.use_imm = 1'b1;
                dec.zero_a  = 1'b1;
                dec.alu_op  = core_pkg::ALU_PASS_B;
            end
            rv_isa_pkg::OPC_AUIPC: begin
                dec.imm     = imm_u;
                dec.use_imm = 1'b1;
                dec.use_pc  = 1'b1;
            end
            default: begin
                bad_opcode = 1'b1;
            end
        endcase

        // Unused source fields stay zero, so only real indices are checked
        dec.illegal = bad_opcode || bad_funct7 ||
                      !idx_ok(dec.rs1) || !idx_ok(dec.rs2) || !idx_ok(dec.rd);
        dec.wen     = !dec.illegal;

        // A write needs a supported major opcode and an implemented destination
        assert (!dec.wen ||
                ((opcode inside {rv_isa_pkg::OPC_OP, rv_isa_pkg::OPC_OP_IMM,
                                 rv_isa_pkg::OPC_LUI, rv_isa_pkg::OPC_AUIPC}) &&
                 idx_ok(instr[11:7])))
            else $error("decoder enabled a write for an illegal instruction");
    end

endmodule

// ==== hdl/core_regfile.sv ====
// --------------------------------------------------------------------
// Integer register file
// Two asynchronous read ports, one write port, x0 hardwired to zero
// and a bypass that forwards a write to a read in the same cycle
// --------------------------------------------------------------------

`timescale 1ns/1ps

module core_regfile #(
    parameter int NUM_REGS = 32
) (
    input  logic                 clk,

    // Write port
    input  rv_isa_pkg::reg_idx_t rd_idx,
    input  rv_isa_pkg::word_t    rd_val,
    input  logic                 rd_wen,

    // Read ports
    input  rv_isa_pkg::reg_idx_t rs1_idx,
    input  rv_isa_pkg::reg_idx_t rs2_idx,
    output rv_isa_pkg::word_t    rs1_val,
    output rv_isa_pkg::word_t    rs2_val
);

    // x1 upward only, unpacked so it infers LUT RAM
    rv_isa_pkg::word_t regs [1:NUM_REGS-1];

    // Writes to x0 dropped here
    always_ff @(posedge clk) begin
        if (rd_wen && (rd_idx != '0)) begin
            regs[rd_idx] <= rd_val;
        end
    end

    // One read port: x0, then the pending write, then storage
    function automatic rv_isa_pkg::word_t read_port(input rv_isa_pkg::reg_idx_t idx);
        rv_isa_pkg::word_t val;
        if (idx == '0) begin
            val = '0;
        end else if (rd_wen && (idx == rd_idx)) begin
            // Same-cycle bypass, lets the next instruction see this result
            val = rd_val;
        end else begin
            val = regs[idx];
        end
        return val;
    endfunction

    always_comb begin
        rs1_val = read_port(rs1_idx);
        rs2_val = read_port(rs2_idx);
    end

    // Decoder must never let an unimplemented destination reach the write port
    assert property (@(posedge clk) rd_wen |-> (int'(rd_idx) < NUM_REGS))
        else $error("register write to unimplemented index %0d", rd_idx);

endmodule

// ==== hdl/core_alu.sv ====
// --------------------------------------------------------------------
// RV32I integer ALU
// Combinational add, subtract, shifts, compares and logic ops,
// plus a pass-through of operand B for LUI
// --------------------------------------------------------------------

`timescale 1ns/1ps

module core_alu (
    input  core_pkg::alu_op_t op,
    input  rv_isa_pkg::word_t a,
    input  rv_isa_pkg::word_t b,
    output rv_isa_pkg::word_t result
);

    // Shift amount, upper bits of b ignored as in RV32I
    logic [4:0] shamt;
    logic       op_ok;

    assign shamt = b[4:0];

    always_comb begin
        op_ok = 1'b1;
        case (op)
            core_pkg::ALU_ADD:    result = a + b;
            core_pkg::ALU_SUB:    result = a - b;
            core_pkg::ALU_SLL:    result = a << shamt;
            // Compares give 0 or 1 in bit 0
            core_pkg::ALU_SLT:    result = {31'b0, $signed(a) < $signed(b)};
            core_pkg::ALU_SLTU:   result = {31'b0, a < b};
            core_pkg::ALU_XOR:    result = a ^ b;
            core_pkg::ALU_SRL:    result = a >> shamt;
            // Arithmetic shift, sign bit replicated
            core_pkg::ALU_SRA:    result = rv_isa_pkg::word_t'($signed(a) >>> shamt);
            core_pkg::ALU_OR:     result = a | b;
            core_pkg::ALU_AND:    result = a & b;
            core_pkg::ALU_PASS_B: result = b;
            default: begin
                result = '0;
                op_ok  = 1'b0;
            end
        endcase

        // Encodings 11..15 are never produced by the decoder
        assert ($isunknown(op) || op_ok)
            else $error("ALU received undefined op %0d", op);
    end

endmodule

// ==== hdl/core_exec_top.sv ====
// --------------------------------------------------------------------
// RV32I execution slice top level
// Two stages: decode and register read, then execute and writeback
// Holds the pc, the execute-stage register and the retire register
// --------------------------------------------------------------------

`timescale 1ns/1ps

module core_exec_top #(
    parameter int NUM_REGS = 32
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                instr_valid,
    input  rv_isa_pkg::word_t   instr,
    output logic                retire_valid,
    output core_pkg::retire_t   retire
);

    // Decode stage
    rv_isa_pkg::word_t  pc;
    core_pkg::decoded_t id_dec;
    rv_isa_pkg::word_t  id_rs1_val;
    rv_isa_pkg::word_t  id_rs2_val;

    // Execute stage
    logic               ex_valid;
    core_pkg::decoded_t ex_dec;
    rv_isa_pkg::word_t  ex_rs1_val;
    rv_isa_pkg::word_t  ex_rs2_val;
    rv_isa_pkg::word_t  ex_pc;
    rv_isa_pkg::word_t  alu_a;
    rv_isa_pkg::word_t  alu_b;
    rv_isa_pkg::word_t  alu_result;
    logic               rf_wen;

    core_decode #(.NUM_REGS(NUM_REGS)) u_decode (
        .instr (instr),
        .dec   (id_dec)
    );

    // Write port driven from execute, so reads in decode see it through the bypass
    assign rf_wen = ex_valid && ex_dec.wen;

    core_regfile #(.NUM_REGS(NUM_REGS)) u_regfile (
        .clk     (clk),
        .rd_idx  (ex_dec.rd),
        .rd_val  (alu_result),
        .rd_wen  (rf_wen),
        .rs1_idx (id_dec.rs1),
        .rs2_idx (id_dec.rs2),
        .rs1_val (id_rs1_val),
        .rs2_val (id_rs2_val)
    );

    // pc advances by 4 on every accepted instruction
    always_ff @(posedge clk) begin
        if (rst) begin
            pc       <= '0;
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= instr_valid;
            if (instr_valid) begin
                pc <= pc + 32'd4;
            end
        end
    end

    // Stage payload, only loaded on a strobe
    always_ff @(posedge clk) begin
        if (instr_valid) begin
            ex_dec     <= id_dec;
            ex_rs1_val <= id_rs1_val;
            ex_rs2_val <= id_rs2_val;
            ex_pc      <= pc;
        end
    end

    // Operand A: zero for LUI, pc for AUIPC, else rs1
    always_comb begin
        if (ex_dec.zero_a) begin
            alu_a = '0;
        end else if (ex_dec.use_pc) begin
            alu_a = ex_pc;
        end else begin
            alu_a = ex_rs1_val;
        end
        alu_b = ex_dec.use_imm ? ex_dec.imm : ex_rs2_val;
    end

    core_alu u_alu (
        .op     (ex_dec.alu_op),
        .a      (alu_a),
        .b      (alu_b),
        .result (alu_result)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= ex_valid;
        end
    end

    // Illegal instructions retire a zero value
    always_ff @(posedge clk) begin
        if (ex_valid) begin
            retire.rd      <= ex_dec.rd;
            retire.value   <= ex_dec.illegal ? '0 : alu_result;
            retire.illegal <= ex_dec.illegal;
        end
    end

    // An illegal instruction in execute must never reach the write port
    assert property (@(posedge clk) disable iff (rst) rf_wen |-> !ex_dec.illegal)
        else $error("register write from an illegal instruction in execute");

endmodule

// ==== test/tb_core_exec.sv ====
// ----------------------------------------------------------------------
// Testbench for the RV32I execution slice
// Replays golden instructions with random idle gaps and checks each
// retire record against the golden rd, value and illegal flag, in order
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module tb_core_exec;

    localparam int NUM_REGS    = 32;
    localparam int MAX_RECORDS = 64;
    // Words per golden line
    localparam int COLS        = 5;
    localparam int SEED        = 32'hd636;

    logic              clk;
    logic              rst;
    logic              instr_valid;
    rv_isa_pkg::word_t instr;
    logic              retire_valid;
    core_pkg::retire_t retire;

    // Flat golden image, COLS words per instruction
    logic [31:0] golden [0:MAX_RECORDS*COLS-1];
    int          num_records;
    // Golden indices of issued instructions awaiting retire
    int          exp_q [$];
    int          retired;
    int          mismatches;
    int          other_errors;

    core_exec_top #(.NUM_REGS(NUM_REGS)) DUT (
        .clk          (clk),
        .rst          (rst),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

    always #5 clk = ~clk;

    // Mismatch report for one field
    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            mismatches++;
            $display("Mismatch %s: expected %08h, actual %08h", name, expected, actual);
        end
    endtask

    task automatic load_golden();
        // Address-tagged fill, gap column never 0 or 1 here
        for (int i = 0; i < MAX_RECORDS * COLS; i++) begin
            golden[i] = 32'hfeed_0000 | 32'(i);
        end
        $readmemh("test/core_exec_golden.txt", golden);
        num_records = 0;
        while (num_records < MAX_RECORDS && golden[num_records*COLS+4] <= 32'd1) begin
            num_records++;
        end
    endtask

    // Idle gap, then a one-cycle strobe
    task automatic issue_record(input int idx);
        int gap;
        if (golden[idx*COLS+4] == 32'd0) begin
            gap = 0;
        end else begin
            gap = int'($urandom % 3);
        end
        repeat (gap) begin
            @(posedge clk);
            instr_valid <= 1'b0;
        end
        @(posedge clk);
        instr_valid <= 1'b1;
        instr       <= golden[idx*COLS];
        exp_q.push_back(idx);
    endtask

    task automatic print_counts();
        $display("Errors: %0d mismatches, %0d other, %0d of %0d instructions retired",
                 mismatches, other_errors, retired, num_records);
    endtask

    // Sampled mid-cycle, away from the DUT's clock edge
    always @(negedge clk) begin
        int idx;
        if (!rst && retire_valid) begin
            if (exp_q.size() == 0) begin
                other_errors++;
                $display("Retire strobe for rd %0d with no instruction left to expect",
                         retire.rd);
            end else begin
                idx = exp_q.pop_front();
                check_value($sformatf("instr %0d rd", idx),
                            golden[idx*COLS+1], 32'(retire.rd));
                check_value($sformatf("instr %0d value", idx),
                            golden[idx*COLS+2], retire.value);
                check_value($sformatf("instr %0d illegal", idx),
                            golden[idx*COLS+3], 32'(retire.illegal));
                retired++;
            end
        end
    end

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        instr_valid  = 1'b0;
        instr        = '0;
        retired      = 0;
        mismatches   = 0;
        other_errors = 0;
        void'($urandom(SEED));
        load_golden();
        if (num_records == 0) begin
            other_errors++;
            $display("Golden file held no instruction records");
        end

        // Two cycles of reset
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        for (int i = 0; i < num_records; i++) begin
            issue_record(i);
        end
        @(posedge clk);
        instr_valid <= 1'b0;

        wait (retired == num_records);
        // A few more cycles to catch stray retires
        repeat (4) @(posedge clk);

        print_counts();
        if (mismatches == 0 && other_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // Worst case is three cycles per issue plus pipeline latency
    initial begin
        wait (num_records > 0);
        repeat (num_records * 4 + 20) @(posedge clk);
        other_errors++;
        $display("Timeout with retires missing, %0d of %0d instructions retired",
                 retired, num_records);
        print_counts();
        $display("Some tests failed");
        $finish;
    end

endmodule

// ==== project.f ====
// Packages first, then RTL bottom-up, then the testbench
hdl/rv_isa_pkg.sv
hdl/core_pkg.sv
hdl/core_decode.sv
hdl/core_regfile.sv
hdl/core_alu.sv
hdl/core_exec_top.sv
test/tb_core_exec.sv

// ==== Makefile ====
# Verilator build and run for the RV32I execution slice

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_core_exec
FILELIST  := project.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := All tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The simulator's exit status is masked by tee, so the log decides
run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "Simulation PASSED"; \
	else \
		echo "Simulation FAILED"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== test/core_exec_golden.txt ====
// Columns: instruction word, expected rd, expected value, expected illegal flag,
// gap mode (0 = issue back-to-back with the previous instruction, 1 = random gap)
// Immediate group, LUI and AUIPC
00500093 01 00000005 0 1  // addi  x1, x0, 5
FFD00113 02 FFFFFFFD 0 1  // addi  x2, x0, -3
800001B7 03 80000000 0 1  // lui   x3, 0x80000
7FF00213 04 000007FF 0 1  // addi  x4, x0, 0x7ff
FFF12293 05 00000001 0 1  // slti  x5, x2, -1
00513313 06 00000000 0 1  // sltiu x6, x2, 5
0FF0C393 07 000000FA 0 1  // xori  x7, x1, 0xff
0F00E413 08 000000F5 0 1  // ori   x8, x1, 0xf0
0FF17493 09 000000FD 0 1  // andi  x9, x2, 0xff
00409513 0A 00000050 0 1  // slli  x10, x1, 4
0041D593 0B 08000000 0 1  // srli  x11, x3, 4
4041D613 0C F8000000 0 1  // srai  x12, x3, 4
00001697 0D 00001030 0 1  // auipc x13, 1 at pc 0x30
12345737 0E 12345000 0 1  // lui   x14, 0x12345
// Register group, signed and unsigned cases
002087B3 0F 00000002 0 1  // add   x15, x1, x2
40408833 10 FFFFF806 0 1  // sub   x16, x1, x4
00A098B3 11 00050000 0 1  // sll   x17, x1, x10 (shamt 16)
00112933 12 00000001 0 1  // slt   x18, x2, x1
001139B3 13 00000000 0 1  // sltu  x19, x2, x1
0083CA33 14 0000000F 0 1  // xor   x20, x7, x8
0011DAB3 15 04000000 0 1  // srl   x21, x3, x1
4011DB33 16 FC000000 0 1  // sra   x22, x3, x1
00E6EBB3 17 12345030 0 1  // or    x23, x13, x14
00E67C33 18 10000000 0 1  // and   x24, x12, x14
// x0 writes retire but never stick, even through the bypass
00708013 00 0000000C 0 1  // addi  x0, x1, 7
00100CB3 19 00000005 0 0  // add   x25, x0, x1
// Dependent chain through the same-cycle bypass
06400D13 1A 00000064 0 1  // addi  x26, x0, 100
001D0D13 1A 00000065 0 0  // addi  x26, x26, 1
01AD0DB3 1B 000000CA 0 0  // add   x27, x26, x26
41AD8E33 1C 00000065 0 0  // sub   x28, x27, x26
002E1E93 1D 00000194 0 0  // slli  x29, x28, 2
// Illegal encodings leave the destination untouched
05500F13 1E 00000055 0 1  // addi  x30, x0, 0x55
00000F7F 1E 00000000 1 1  // unknown opcode, rd field x30
000F0FB3 1F 00000055 0 0  // add   x31, x30, x0
6041DF13 1E 00000000 1 1  // srai  x30, x3, 4 with funct7 0110000
0241DF13 1E 00000000 1 1  // srli  x30, x3, 4 with funct7 0000001
000F0F93 1F 00000055 0 0  // addi  x31, x30, 0
// pc counts illegal instructions too
FFFFF297 05 FFFFF094 0 1  // auipc x5, 0xfffff at pc 0x94
000000B3 01 00000000 0 1  // add   x1, x0, x0
